// ==== src/uart_pkg.sv ====
package uart_pkg;

    // Word index, taken from address bits 3:2.
    localparam logic [1:0] uart_reg_clk_div = 2'd0;
    localparam logic [1:0] uart_reg_status  = 2'd1;
    localparam logic [1:0] uart_reg_data    = 2'd2;

    // Start bit, eight data bits, stop bit.
    localparam int uart_frame_bits = 10;

    // One bit lasts divider + 1 clock cycles.
    typedef logic [15:0] uart_div_t;

    typedef struct packed {
        logic [31:0] address;
        logic        sel;
        logic        read;
        logic [3:0]  write_mask;
        logic [31:0] write_value;
    } uart_bus_req_t;

    typedef struct packed {
        logic       valid;
        logic [7:0] data;
    } uart_tx_req_t;

    typedef struct packed {
        logic       valid;
        logic [7:0] data;
    } uart_rx_byte_t;

    typedef struct packed {
        logic [15:0] zero;
        uart_div_t   divider;
    } uart_div_view_t;

    typedef struct packed {
        logic [29:0] zero;
        logic        rx_ready;
        logic        tx_ready;
    } uart_status_view_t;

    // Fill is all ones while the holding register is empty.
    typedef struct packed {
        logic [23:0] fill;
        logic [7:0]  value;
    } uart_data_view_t;

    // One register word, three ways to read it.
    typedef union packed {
        uart_div_view_t    div;
        uart_status_view_t status;
        uart_data_view_t   data;
    } uart_reg_word_u;

endpackage

// ==== src/uart_bus_regs.sv ====
`timescale 1ns/1ps

module uart_bus_regs
    import uart_pkg::*;
(
    input  logic           clk,
    input  logic           reset,
    input  uart_bus_req_t  bus_req,
    output uart_reg_word_u read_value,
    output uart_tx_req_t   tx_req,
    input  logic           tx_busy,
    input  uart_rx_byte_t  rx_byte,
    output uart_div_t      clk_div
);

    logic [1:0]     word;
    uart_reg_word_u write_word;
    logic           div_sel;
    logic           data_sel;

    logic [7:0]     rx_data;
    logic           rx_ready;

    assign word       = bus_req.address[3:2];
    assign write_word = bus_req.write_value;
    assign div_sel    = bus_req.sel && (word == uart_reg_clk_div);
    assign data_sel   = bus_req.sel && (word == uart_reg_data);

    // Serializer drops this itself when busy.
    assign tx_req.valid = data_sel && bus_req.write_mask[0];
    assign tx_req.data  = write_word.data.value;

    // Divider, byte-masked.
    always_ff @(posedge clk) begin
        if (reset) begin
            clk_div <= '0;
        end else if (div_sel) begin
            if (bus_req.write_mask[1])
                clk_div[15:8] <= write_word.div.divider[15:8];
            if (bus_req.write_mask[0])
                clk_div[7:0] <= write_word.div.divider[7:0];
        end
    end

    // Receive holding register. A new byte beats a clearing read.
    always_ff @(posedge clk) begin
        if (reset) begin
            rx_ready <= 1'b0;
        end else if (rx_byte.valid) begin
            rx_ready <= 1'b1;
        end else if (data_sel && bus_req.read) begin
            rx_ready <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rx_byte.valid)
            rx_data <= rx_byte.data; // Overwrites any unread byte.
    end

    always_comb begin
        read_value = '0;
        if (bus_req.sel) begin
            case (word)
                uart_reg_clk_div: begin
                    read_value.div.divider = clk_div;
                end
                uart_reg_status: begin
                    read_value.status.rx_ready = rx_ready;
                    read_value.status.tx_ready = !tx_busy;
                end
                uart_reg_data: begin
                    read_value.data.fill  = {24{~rx_ready}};
                    read_value.data.value = rx_ready ? rx_data : 8'h00;
                end
                default: begin
                    read_value = '0; // Word 3 reads as zero.
                end
            endcase
        end
    end

    // A strobed byte must be fully sampled.
    a_rx_byte_known: assert property (
        @(posedge clk) disable iff (reset)
        rx_byte.valid |-> !$isunknown(rx_byte.data)
    );

endmodule

// ==== src/uart_tx.sv ====
`timescale 1ns/1ps

module uart_tx
    import uart_pkg::*;
(
    input  logic         clk,
    input  logic         reset,
    input  uart_div_t    clk_div,
    input  uart_tx_req_t tx_req,
    output logic         tx,
    output logic         tx_busy
);

    logic [uart_frame_bits-1:0] shift;
    logic [3:0]                 slots; // Bit slots left in the frame.
    uart_div_t                  clks;

    assign tx      = shift[0];
    assign tx_busy = (slots != 4'd0);

    always_ff @(posedge clk) begin
        if (reset) begin
            shift <= '1; // Line idles high.
            slots <= '0;
            clks  <= '0;
        end else if (tx_req.valid && !tx_busy) begin
            // Stop, data LSB first, start.
            shift <= {1'b1, tx_req.data, 1'b0};
            slots <= 4'(uart_frame_bits);
            clks  <= clk_div;
        end else if (tx_busy) begin
            if (clks != '0) begin
                clks <= clks - 1'b1;
            end else begin
                clks  <= clk_div;
                slots <= slots - 1'b1;
                shift <= {1'b1, shift[uart_frame_bits-1:1]};
            end
        end
    end

    // Line is high whenever no frame is in flight.
    a_idle_high: assert property (
        @(posedge clk) disable iff (reset)
        !tx_busy |-> tx
    );

endmodule

// ==== src/uart_rx.sv ====
`timescale 1ns/1ps

module uart_rx
    import uart_pkg::*;
(
    input  logic          clk,
    input  logic          reset,
    input  uart_div_t     clk_div,
    input  logic          rx,
    output uart_rx_byte_t rx_byte
);

    logic [3:0] slots; // Zero while idle.
    uart_div_t  clks;
    logic [7:0] shift;
    logic       start_slot;
    logic       stop_slot;

    assign start_slot = (slots == 4'(uart_frame_bits));
    assign stop_slot  = (slots == 4'd1);

    always_ff @(posedge clk) begin
        rx_byte.valid <= 1'b0;

        if (reset) begin
            slots <= '0;
            clks  <= '0;
        end else if (slots == 4'd0) begin
            // Falling line starts a frame, first sample half a bit in.
            if (!rx) begin
                clks  <= {1'b0, clk_div[15:1]};
                slots <= 4'(uart_frame_bits);
            end
        end else if (clks != '0) begin
            clks <= clks - 1'b1;
        end else begin
            clks  <= clk_div;
            slots <= slots - 1'b1;

            if (start_slot) begin
                if (rx)
                    slots <= '0; // Glitch, back to idle.
            end else if (stop_slot) begin
                rx_byte.valid <= rx; // Framing error drops the byte.
                rx_byte.data  <= shift;
            end else begin
                shift <= {rx, shift[7:1]};
            end
        end
    end

    a_valid_pulse: assert property (
        @(posedge clk) disable iff (reset)
        rx_byte.valid |=> !rx_byte.valid
    );

endmodule

// ==== src/uart_top.sv ====
`timescale 1ns/1ps

module uart_top
    import uart_pkg::*;
(
    input  logic           clk,
    input  logic           reset,
    input  logic           rx,
    input  uart_bus_req_t  bus_req,
    output logic           tx,
    output uart_reg_word_u read_value
);

    uart_tx_req_t  tx_req;
    logic          tx_busy;
    uart_div_t     clk_div;
    uart_rx_byte_t rx_byte;

    uart_bus_regs u_bus_regs (
        .clk        (clk),
        .reset      (reset),
        .bus_req    (bus_req),
        .read_value (read_value),
        .tx_req     (tx_req),
        .tx_busy    (tx_busy),
        .rx_byte    (rx_byte),
        .clk_div    (clk_div)
    );

    uart_tx u_tx (
        .clk     (clk),
        .reset   (reset),
        .clk_div (clk_div),
        .tx_req  (tx_req),
        .tx      (tx),
        .tx_busy (tx_busy)
    );

    uart_rx u_rx (
        .clk     (clk),
        .reset   (reset),
        .clk_div (clk_div),
        .rx      (rx),
        .rx_byte (rx_byte)
    );

endmodule

// ==== test/uart_tb_cases.svh ====
// Testbench-only operations applied by the table loop.
typedef enum logic [3:0] {
    op_write,
    op_read,
    op_read_off,   // Read with sel low.
    op_read_rx,    // Data read of the last byte sent.
    op_send,
    op_send_rand,
    op_send_busy,  // Second write lands while busy.
    op_inject,     // Value holds 10 frame bits, LSB first.
    op_glitch      // Value holds the low pulse length in cycles.
} tb_op_t;

typedef struct {
    tb_op_t      op;
    logic [31:0] address;
    logic [3:0]  mask;
    logic [31:0] value;
    logic [31:0] expected;
    string       name;
} case_row_t;

case_row_t cases[$];

task automatic add_case(input tb_op_t op, input logic [31:0] address, input logic [3:0] mask,
                        input logic [31:0] value, input logic [31:0] expected,
                        input string name);
    case_row_t row;
    row.op       = op;
    row.address  = address;
    row.mask     = mask;
    row.value    = value;
    row.expected = expected;
    row.name     = name;
    cases.push_back(row);
endtask

task automatic build_table();
    add_case(op_read,      32'h4, 4'h0, 32'h0000_0000, 32'h0000_0001, "reset status");
    add_case(op_read,      32'h8, 4'h0, 32'h0000_0000, 32'hffff_ff00, "reset data");
    add_case(op_read_off,  32'h4, 4'h0, 32'h0000_0000, 32'h0000_0000, "read without sel");
    add_case(op_write,     32'h0, 4'h2, 32'h0000_1234, 32'h0000_0000, "divider high byte");
    add_case(op_write,     32'h0, 4'h1, 32'h0000_0056, 32'h0000_0000, "divider low byte");
    add_case(op_read,      32'h0, 4'h0, 32'h0000_0000, 32'h0000_1256, "divider readback");
    add_case(op_read,      32'hc, 4'h0, 32'h0000_0000, 32'h0000_0000, "word 3 reads zero");
    add_case(op_write,     32'h0, 4'h3, 32'h0000_0003, 32'h0000_0000, "divider to 3");
    add_case(op_read,      32'h0, 4'h0, 32'h0000_0000, 32'h0000_0003, "divider is 3");
    add_case(op_send,      32'h8, 4'h1, 32'h0000_00a5, 32'h0000_0000, "send a5");
    add_case(op_read,      32'h4, 4'h0, 32'h0000_0000, 32'h0000_0003, "rx ready after loopback");
    add_case(op_read,      32'h8, 4'h0, 32'h0000_0000, 32'h0000_00a5, "loopback byte");
    add_case(op_read,      32'h4, 4'h0, 32'h0000_0000, 32'h0000_0001, "rx ready cleared");
    add_case(op_send_rand, 32'h8, 4'h1, 32'h0000_0000, 32'h0000_0000, "send random byte");
    add_case(op_read_rx,   32'h8, 4'h0, 32'h0000_0000, 32'h0000_0000, "random byte received");
    add_case(op_send_busy, 32'h8, 4'h1, 32'h0000_003c, 32'h0000_0000, "write while busy");
    add_case(op_read,      32'h8, 4'h0, 32'h0000_0000, 32'h0000_003c, "first byte only");
    add_case(op_read,      32'h4, 4'h0, 32'h0000_0000, 32'h0000_0001, "no second frame");
    add_case(op_glitch,    32'h0, 4'h0, 32'h0000_0001, 32'h0000_0000, "false start");
    add_case(op_read,      32'h4, 4'h0, 32'h0000_0000, 32'h0000_0001, "no byte from glitch");
    add_case(op_inject,    32'h0, 4'h0, 32'h0000_00aa, 32'h0000_0000, "low stop bit");
    add_case(op_read,      32'h4, 4'h0, 32'h0000_0000, 32'h0000_0001, "framing error dropped");
    add_case(op_inject,    32'h0, 4'h0, 32'h0000_0386, 32'h0000_0000, "inject good frame");
    add_case(op_read,      32'h8, 4'h0, 32'h0000_0000, 32'h0000_00c3, "injected byte");
endtask

// ==== test/uart_tb.sv ====
`timescale 1ns/1ps

module uart_tb
    import uart_pkg::*;
();

    logic           clk;
    logic           reset;
    logic           rx;
    logic           tx;
    logic           rx_drive;
    logic           loop_back;
    uart_bus_req_t  bus_req;
    uart_reg_word_u read_value;

    uart_div_t  div_model; // Divider as the bus writes have set it.
    logic [7:0] last_byte;
    int         row_errors;
    int         pass_count;
    int         fail_count;
    logic       table_ready;

    `include "uart_tb_cases.svh"

    assign rx = loop_back ? tx : rx_drive;

    uart_top dut_i (
        .clk        (clk),
        .reset      (reset),
        .rx         (rx),
        .bus_req    (bus_req),
        .tx         (tx),
        .read_value (read_value)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic uart_div_t apply_div(input uart_div_t div, input logic [3:0] mask,
                                            input logic [31:0] value);
        uart_div_t next;
        next = div;
        if (mask[0])
            next[7:0] = value[7:0];
        if (mask[1])
            next[15:8] = value[15:8];
        return next;
    endfunction

    // Frame rows get three frame lengths, every row a few bus cycles.
    function automatic int watchdog_cycles();
        uart_div_t div;
        int        total;
        div   = '0;
        total = 500;
        foreach (cases[i]) begin
            if (cases[i].op == op_write && cases[i].address[3:2] == 2'd0)
                div = apply_div(div, cases[i].mask, cases[i].value);
            total += 20;
            if (cases[i].op inside {op_send, op_send_rand, op_send_busy, op_inject, op_glitch})
                total += 3 * 10 * (int'(div) + 1);
        end
        return total;
    endfunction

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] want);
        assert (got === want) else begin
            $display("Error at %0d ns: %s is 0x%08h, expected 0x%08h", $time, what, got, want);
            row_errors++;
        end
    endtask

    // Tasks start and end on a falling edge.
    task automatic bus_write(input logic [31:0] address, input logic [3:0] mask,
                             input logic [31:0] value);
        bus_req             = '0;
        bus_req.address     = address;
        bus_req.sel         = 1'b1;
        bus_req.write_mask  = mask;
        bus_req.write_value = value;
        if (address[3:2] == 2'd0)
            div_model = apply_div(div_model, mask, value);
        @(posedge clk);
        @(negedge clk);
        bus_req = '0;
    endtask

    task automatic bus_read(input logic [31:0] address, input logic sel,
                            output logic [31:0] value);
        bus_req         = '0;
        bus_req.address = address;
        bus_req.sel     = sel;
        bus_req.read    = 1'b1;
        #2;
        value = read_value; // Combinational, settled well before the edge.
        @(posedge clk);
        @(negedge clk);
        bus_req = '0;
    endtask

    task automatic send_frame(input logic [7:0] data, input logic write_again);
        int          bit_cycles;
        int          n;
        int          k;
        int          first_ready;
        logic [9:0]  frame;
        logic [31:0] st;
        bit_cycles  = int'(div_model) + 1;
        n           = 10 * bit_cycles;
        frame       = {1'b1, data, 1'b0};
        first_ready = -1;
        last_byte   = data;
        bus_write(32'h8, 4'h1, {24'h0, data});
        k = 0;
        if (write_again) begin
            bus_write(32'h8, 4'h1, {24'h0, ~data});
            k = 1;
        end
        // k counts edges since the accepting one.
        while (first_ready < 0 && k <= n + 2 * bit_cycles) begin
            if (k % bit_cycles == bit_cycles / 2 && k / bit_cycles < 10) begin
                assert (tx === frame[k / bit_cycles]) else begin
                    $display("Error at %0d ns: tx slot %0d is %b, expected %b", $time,
                             k / bit_cycles, tx, frame[k / bit_cycles]);
                    row_errors++;
                end
            end
            bus_read(32'h4, 1'b1, st);
            if (st[0])
                first_ready = k;
            k++;
        end
        if (first_ready < 0) begin
            $display("Transmitter still busy %0d cycles after the write", k);
            row_errors++;
        end else begin
            check_value("busy cycles", 32'(first_ready), 32'(n));
        end
        repeat (bit_cycles + 2) @(negedge clk); // Receiver finishes the stop bit.
    endtask

    task automatic inject_frame(input logic [9:0] frame);
        int bit_cycles;
        bit_cycles = int'(div_model) + 1;
        loop_back  = 1'b0;
        for (int j = 0; j < 10; j++) begin
            rx_drive = frame[j];
            repeat (bit_cycles) @(negedge clk);
        end
        rx_drive = 1'b1;
        repeat (2 * bit_cycles) @(negedge clk);
        loop_back = 1'b1;
    endtask

    task automatic glitch_pulse(input int len);
        int bit_cycles;
        bit_cycles = int'(div_model) + 1;
        loop_back  = 1'b0;
        rx_drive   = 1'b0;
        repeat (len) @(negedge clk);
        rx_drive = 1'b1;
        repeat (12 * bit_cycles) @(negedge clk); // Longer than a whole frame.
        loop_back = 1'b1;
    endtask

    task automatic run_row(input case_row_t row);
        logic [31:0] got;
        case (row.op)
            op_write: bus_write(row.address, row.mask, row.value);
            op_read: begin
                bus_read(row.address, 1'b1, got);
                check_value(row.name, got, row.expected);
            end
            op_read_off: begin
                bus_read(row.address, 1'b0, got);
                check_value(row.name, got, row.expected);
            end
            op_read_rx: begin
                bus_read(row.address, 1'b1, got);
                check_value(row.name, got, {24'h0, last_byte});
            end
            op_send:      send_frame(row.value[7:0], 1'b0);
            op_send_rand: send_frame(8'($urandom), 1'b0);
            op_send_busy: send_frame(row.value[7:0], 1'b1);
            op_inject:    inject_frame(row.value[9:0]);
            op_glitch:    glitch_pulse(int'(row.value));
            default: begin
                $display("Row %s has an unknown operation", row.name);
                row_errors++;
            end
        endcase
    endtask

    initial begin
        reset       = 1'b1;
        bus_req     = '0;
        rx_drive    = 1'b1;
        loop_back   = 1'b1;
        div_model   = '0;
        last_byte   = 8'h00;
        pass_count  = 0;
        fail_count  = 0;
        table_ready = 1'b0;
        void'($urandom(32'hc45f_683e));
        build_table();
        table_ready = 1'b1;
        repeat (3) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        foreach (cases[i]) begin
            row_errors = 0;
            run_row(cases[i]);
            if (row_errors == 0) begin
                pass_count++;
                $display("PASS %s", cases[i].name);
            end else begin
                fail_count++;
                $display("FAIL %s", cases[i].name);
            end
        end

        $display("Summary: %0d passed, %0d failed, %0d total", pass_count, fail_count,
                 pass_count + fail_count);
        if (fail_count == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

    // Watchdog.
    initial begin
        int limit;
        wait (table_ready);
        limit = watchdog_cycles();
        repeat (limit) @(posedge clk);
        $display("Timeout: run did not finish within %0d clock cycles", limit);
        $display("test failed");
        $finish;
    end

endmodule

// ==== files.f ====
src/uart_pkg.sv
src/uart_bus_regs.sv
src/uart_tx.sv
src/uart_rx.sv
src/uart_top.sv
+incdir+test
test/uart_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the UART testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module uart_tb -f files.f -o uart_sim

status=0
./obj_dir/uart_sim > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "test failed" sim.log; then
    exit 1
fi
if [ "$status" -ne 0 ] || ! grep -q "test passed" sim.log; then
    echo "Simulation ended without a result"
    exit 1
fi
exit 0
